/* Makefile */
# Verilator flow for the SIMD upstream interface

VERILATOR  ?= verilator
TOP        := tb_simd_upstream_intf
FILELIST   := simd_upstream_intf.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := Simulation passed

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run; the result comes from the log
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Run passed"; \
	else \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* simd_lane_capture.sv */
/*
  Registers the SIMD lane values and valids, one cycle from input to copy.
  The tag is only loaded while some lane valid is high, so it survives the
  valids dropping at the end of a message.
*/

`timescale 1ns/1ns
`default_nettype none

module simd_lane_capture #(
  parameter int NUM_LANES = 8
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire simd_upstream_pkg::lane_t lane_data [NUM_LANES],
  input  wire [NUM_LANES-1:0]         lane_valid,
  input  wire simd_upstream_pkg::tag_t tag,
  output simd_upstream_pkg::lane_t    cap_lanes [NUM_LANES],
  output simd_upstream_pkg::tag_t     cap_tag,
  output logic                        all_loaded
);

  // Registered copy of the lane valids
  logic [NUM_LANES-1:0] valid_q;

  // Lane values and valids, both cleared on reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_LANES; i++)
        cap_lanes[i] <= '0;
      valid_q <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_LANES; i++)
        cap_lanes[i] <= lane_data[i];
      valid_q <= lane_valid;
    end
  end

  // Tag follows the last cycle with any lane valid
  always_ff @(posedge clk)
  begin
    if (|lane_valid)
      cap_tag <= tag;
  end

  // Message is ready once every lane has been loaded
  assign all_loaded = &valid_q;

endmodule

`default_nettype wire

/* simd_upstream_golden.txt */
// Per message: tag, then lanes 0..7 as 16-bit hex
// Then 4 beats, one per line: cntl type data oob (SOM=1 MOM=0 EOM=2, DATA=1 NA=0)
11 0001 0002 0003 0004 0005 0006 0007 0008
1 1 00020001 11
0 0 00040003 11
0 0 00060005 11
2 0 00080007 11
a5 1234 5678 9abc def0 0f0f f0f0 aaaa 5555
1 1 56781234 a5
0 0 def09abc a5
0 0 f0f00f0f a5
2 0 5555aaaa a5
3c ffff 0000 8000 0001 7fff fffe c3c3 3c3c
1 1 0000ffff 3c
0 0 00018000 3c
0 0 fffe7fff 3c
2 0 3c3cc3c3 3c
00 beef dead cafe babe 1111 2222 4444 8888
1 1 deadbeef 00
0 0 babecafe 00
0 0 22221111 00
2 0 88884444 00
ff 0a0b 0c0d 1a1b 1c1d 2a2b 2c2d 3a3b 3c3d
1 1 0c0d0a0b ff
0 0 1c1d1a1b ff
0 0 2c2d2a2b ff
2 0 3c3d3a3b ff

/* simd_upstream_intf.f */
simd_upstream_pkg.sv
simd_lane_capture.sv
upstream_msg_framer.sv
upstream_fifo.sv
upstream_out_pipe.sv
simd_upstream_intf.sv
tb_simd_upstream_intf.sv

/* simd_upstream_intf.sv */
/*
  Upstream interface of a SIMD processing element, top level.
  Lane results are framed into beats, buffered and sent under valid/ready.
  Defaults give 8 lanes of 16 bits in 4 beats of 32 bits per message.
*/

`timescale 1ns/1ns
`default_nettype none

module simd_upstream_intf #(
  parameter int NUM_LANES   = 8,
  parameter int FIFO_DEPTH  = 8,
  parameter int AFULL_LEVEL = 6
) (
  input  wire                           clk,
  input  wire                           rst,
  // SIMD side
  input  wire simd_upstream_pkg::lane_t lane_data [NUM_LANES],
  input  wire [NUM_LANES-1:0]           lane_valid,
  input  wire simd_upstream_pkg::tag_t  tag,
  output logic                          regs_ready,
  output logic                          regs_complete,
  // Upstream bus
  output logic                          out_valid,
  output simd_upstream_pkg::beat_cntl_t out_cntl,
  output simd_upstream_pkg::beat_type_t out_type,
  output simd_upstream_pkg::beat_data_t out_data,
  output simd_upstream_pkg::tag_t       out_oob,
  input  wire                           out_ready
);

  import simd_upstream_pkg::*;

  // ----------------------------------------
  // Internal wiring
  // ----------------------------------------
  lane_t      cap_lanes [NUM_LANES];
  tag_t       cap_tag;
  logic       all_loaded;
  logic       wr_en;
  beat_word_t wr_word;
  logic       almost_full;
  beat_word_t rd_word;
  logic       empty;
  logic       rd_en;

  simd_lane_capture #(
    .NUM_LANES (NUM_LANES)
  ) i_simd_lane_capture (
    .clk        (clk),
    .rst        (rst),
    .lane_data  (lane_data),
    .lane_valid (lane_valid),
    .tag        (tag),
    .cap_lanes  (cap_lanes),
    .cap_tag    (cap_tag),
    .all_loaded (all_loaded)
  );

  upstream_msg_framer #(
    .NUM_LANES (NUM_LANES)
  ) i_upstream_msg_framer (
    .clk           (clk),
    .rst           (rst),
    .cap_lanes     (cap_lanes),
    .cap_tag       (cap_tag),
    .all_loaded    (all_loaded),
    .almost_full   (almost_full),
    .wr_en         (wr_en),
    .wr_word       (wr_word),
    .regs_ready    (regs_ready),
    .regs_complete (regs_complete)
  );

  upstream_fifo #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .AFULL_LEVEL (AFULL_LEVEL)
  ) i_upstream_fifo (
    .clk         (clk),
    .rst         (rst),
    .wr_en       (wr_en),
    .wr_word     (wr_word),
    .rd_en       (rd_en),
    .rd_word     (rd_word),
    .empty       (empty),
    .almost_full (almost_full)
  );

  // Pipe reads the FIFO and drives the bus
  upstream_out_pipe i_upstream_out_pipe (
    .clk       (clk),
    .rst       (rst),
    .rd_word   (rd_word),
    .empty     (empty),
    .out_ready (out_ready),
    .rd_en     (rd_en),
    .out_valid (out_valid),
    .out_cntl  (out_cntl),
    .out_type  (out_type),
    .out_data  (out_data),
    .out_oob   (out_oob)
  );

endmodule

`default_nettype wire

/* simd_upstream_pkg.sv */
/*
  Shared widths, beat codes and framer states for the SIMD upstream interface.
  A bus beat is twice the lane width, so two lanes travel per beat.
  The FIFO word packs control, type, data and tag from the top bits down.
*/

`default_nettype none

package simd_upstream_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int LANE_W = 16;
  localparam int TAG_W  = 8;
  localparam int DATA_W = 32;
  localparam int CNTL_W = 2;
  localparam int TYPE_W = 2;
  localparam int WORD_W = CNTL_W + TYPE_W + DATA_W + TAG_W;

  typedef logic [LANE_W-1:0] lane_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [DATA_W-1:0] beat_data_t;
  typedef logic [CNTL_W-1:0] beat_cntl_t;
  typedef logic [TYPE_W-1:0] beat_type_t;
  typedef logic [WORD_W-1:0] beat_word_t;

  // ----------------------------------------
  // Beat position codes
  // ----------------------------------------
  // MOM is the idle code between start and end
  localparam beat_cntl_t CNTL_MOM = 2'b00;
  localparam beat_cntl_t CNTL_SOM = 2'b01;
  localparam beat_cntl_t CNTL_EOM = 2'b10;

  // Beat type, only the first beat of a message carries DATA
  localparam beat_type_t TYPE_NA   = 2'b00;
  localparam beat_type_t TYPE_DATA = 2'b01;

  // ----------------------------------------
  // Framer FSM
  // ----------------------------------------
  typedef enum logic [1:0] {
    WAIT     = 2'd0,
    SEND     = 2'd1,
    COMPLETE = 2'd2
  } framer_state_t;

endpackage

`default_nettype wire

/* tb_simd_upstream_intf.sv */
/*
  Testbench for the SIMD upstream interface at its default parameters.
  Messages and expected beats come from simd_upstream_golden.txt in the
  project root. out_ready follows an LFSR to apply back-pressure.
*/

`timescale 1ns/1ns
`default_nettype none

module tb_simd_upstream_intf;

  import simd_upstream_pkg::*;

  // ----------------------------------------
  // Test geometry
  // ----------------------------------------
  localparam int NUM_LANES   = 8;
  localparam int NUM_BEATS   = 4;
  localparam int NUM_MSGS    = 5;
  // Tag, lanes, then four words per beat
  localparam int MSG_WORDS   = 1 + NUM_LANES + 4 * NUM_BEATS;
  localparam int GOLD_WORDS  = NUM_MSGS * MSG_WORDS;
  localparam int TOTAL_BEATS = NUM_MSGS * NUM_BEATS;
  localparam int MAX_CYCLES  = 200 * NUM_MSGS;
  localparam logic [7:0] LFSR_SEED = 8'd82;

  logic                 clk = 1'b0;
  logic                 rst;
  lane_t                lane_data [NUM_LANES];
  logic [NUM_LANES-1:0] lane_valid;
  tag_t                 tag;
  logic                 regs_ready;
  logic                 regs_complete;
  logic                 out_valid;
  beat_cntl_t           out_cntl;
  beat_type_t           out_type;
  beat_data_t           out_data;
  tag_t                 out_oob;
  logic                 out_ready;

  logic [31:0] golden [GOLD_WORDS];
  logic [7:0]  lfsr_state = LFSR_SEED;
  int          errors = 0;
  int          checks = 0;
  int          beats_seen = 0;
  int          writes_seen = 0;
  int          msgs_done = 0;
  int          cycles = 0;

  // Previous bus cycle values for the stall hold check
  logic        prev_valid;
  logic        prev_ready;
  logic        prev_complete;
  beat_cntl_t  prev_cntl;
  beat_type_t  prev_type;
  beat_data_t  prev_data;
  tag_t        prev_oob;
  // Any lane valid seen one and two edges back
  logic        valid_d1;
  logic        valid_d2;

  always #4 clk = ~clk;

  simd_upstream_intf #(
    .NUM_LANES   (NUM_LANES),
    .FIFO_DEPTH  (8),
    .AFULL_LEVEL (6)
  ) i_simd_upstream_intf (
    .clk           (clk),
    .rst           (rst),
    .lane_data     (lane_data),
    .lane_valid    (lane_valid),
    .tag           (tag),
    .regs_ready    (regs_ready),
    .regs_complete (regs_complete),
    .out_valid     (out_valid),
    .out_cntl      (out_cntl),
    .out_type      (out_type),
    .out_data      (out_data),
    .out_oob       (out_oob),
    .out_ready     (out_ready)
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // Taps 8,6,5,4
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  function automatic logic [31:0] expected_cntl(input int b);
    if (b == 0)
      return 32'(CNTL_SOM);
    else if (b == NUM_BEATS - 1)
      return 32'(CNTL_EOM);
    return 32'(CNTL_MOM);
  endfunction

  function automatic logic [31:0] expected_type(input int b);
    return (b == 0) ? 32'(TYPE_DATA) : 32'(TYPE_NA);
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic flag_error(input string what);
    errors++;
    $display("[ERROR] %0t ns %s", $time, what);
  endtask

  // Golden beats must follow the framing rules of their own lanes and tag
  task automatic check_golden();
    int          base;
    int          bw;
    logic [31:0] pair;
    for (int m = 0; m < NUM_MSGS; m++)
    begin
      base = m * MSG_WORDS;
      for (int b = 0; b < NUM_BEATS; b++)
      begin
        bw   = base + 1 + NUM_LANES + 4 * b;
        pair = {golden[base + 2 * b + 2][15:0], golden[base + 2 * b + 1][15:0]};
        if (golden[bw] !== expected_cntl(b) || golden[bw + 1] !== expected_type(b) ||
            golden[bw + 2] !== pair || golden[bw + 3] !== golden[base])
          flag_error($sformatf("golden beat %0d of message %0d breaks framing", b, m));
      end
    end
  endtask

  // One accepted beat against its golden entry
  task automatic check_beat(input int idx);
    int base;
    base = (idx / NUM_BEATS) * MSG_WORDS + 1 + NUM_LANES + 4 * (idx % NUM_BEATS);
    compare_field("out_cntl", 32'(out_cntl), golden[base]);
    compare_field("out_type", 32'(out_type), golden[base + 1]);
    compare_field("out_data", out_data, golden[base + 2]);
    compare_field("out_oob", 32'(out_oob), golden[base + 3]);
  endtask

  // ----------------------------------------
  // Back-pressure and timeout
  // ----------------------------------------
  always @(negedge clk)
  begin
    lfsr_state = lfsr_next(lfsr_state);
    out_ready  = lfsr_state[0];
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout after %0d cycles, %0d of %0d beats seen",
               cycles, beats_seen, TOTAL_BEATS);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Bus and flag monitor
  // ----------------------------------------
  always @(posedge clk)
  begin
    if (rst)
    begin
      prev_valid    = 1'b0;
      prev_ready    = 1'b0;
      prev_complete = 1'b0;
      valid_d1      = 1'b0;
      valid_d2      = 1'b0;
    end
    else
    begin
      // A stalled beat must stay put
      if (prev_valid && !prev_ready)
      begin
        if (!out_valid)
          flag_error("out_valid dropped while a beat was stalled");
        compare_field("out_cntl held", 32'(out_cntl), 32'(prev_cntl));
        compare_field("out_type held", 32'(out_type), 32'(prev_type));
        compare_field("out_data held", out_data, prev_data);
        compare_field("out_oob held", 32'(out_oob), 32'(prev_oob));
      end
      if (out_valid && out_ready)
      begin
        if (beats_seen >= TOTAL_BEATS)
          flag_error("extra beat after the last message");
        else
          check_beat(beats_seen);
        beats_seen++;
      end
      // regs_complete only once all four beats are in the FIFO
      if (regs_complete && !prev_complete)
      begin
        if (writes_seen != NUM_BEATS * (msgs_done + 1))
          flag_error("regs_complete rose before the EOM beat was written");
        msgs_done++;
      end
      // Capture adds a cycle, so the flag may only fall once the valids were low two edges back
      if (!regs_complete && prev_complete && valid_d2)
        flag_error("regs_complete fell before the lane valids dropped");
      if (regs_ready && (writes_seen % NUM_BEATS) != 0)
        flag_error("regs_ready high in the middle of a message");
      if (regs_ready && regs_complete)
        flag_error("regs_ready and regs_complete high together");
      if (i_simd_upstream_intf.wr_en)
        writes_seen++;
      prev_valid    = out_valid;
      prev_ready    = out_ready;
      prev_complete = regs_complete;
      prev_cntl     = out_cntl;
      prev_type     = out_type;
      prev_data     = out_data;
      prev_oob      = out_oob;
      valid_d2      = valid_d1;
      valid_d1      = |lane_valid;
    end
  end

  // ----------------------------------------
  // SIMD-side stimulus
  // ----------------------------------------
  initial
  begin
    int base;
    rst        = 1'b1;
    lane_valid = '0;
    tag        = '0;
    out_ready  = 1'b0;
    for (int i = 0; i < NUM_LANES; i++)
      lane_data[i] = '0;
    $readmemh("simd_upstream_golden.txt", golden);
    check_golden();

    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    // Idle state right after reset
    compare_field("out_valid", 32'(out_valid), 32'd0);
    compare_field("regs_complete", 32'(regs_complete), 32'd0);
    compare_field("regs_ready", 32'(regs_ready), 32'd1);

    for (int m = 0; m < NUM_MSGS; m++)
    begin
      base = m * MSG_WORDS;
      while (!regs_ready)
        @(negedge clk);
      tag = golden[base][7:0];
      for (int i = 0; i < NUM_LANES; i++)
        lane_data[i] = golden[base + 1 + i][15:0];
      lane_valid = '1;
      // Hold valids until the framer reports the message written
      while (!regs_complete)
        @(negedge clk);
      lane_valid = '0;
      while (regs_complete)
        @(negedge clk);
    end

    // Drain, then a few idle cycles to catch stray beats
    while (beats_seen < TOTAL_BEATS)
      @(negedge clk);
    repeat (10) @(negedge clk);
    if (beats_seen != TOTAL_BEATS)
      flag_error("beat count differs from the golden file");
    if (msgs_done != NUM_MSGS)
      flag_error("regs_complete did not pulse once per message");

    $display("Checks: %0d, errors: %0d, beats: %0d of %0d",
             checks, errors, beats_seen, TOTAL_BEATS);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* upstream_fifo.sv */
/*
  Synchronous FIFO of framed beats with a registered read port.
  A word written is readable from the next cycle; rd_word updates on rd_en.
  AFULL_LEVEL must leave room for the beat written while the flag settles.
*/

`timescale 1ns/1ns
`default_nettype none

module upstream_fifo #(
  parameter int FIFO_DEPTH  = 8,
  parameter int AFULL_LEVEL = 6
) (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                wr_en,
  input  wire simd_upstream_pkg::beat_word_t wr_word,
  input  wire                                rd_en,
  output simd_upstream_pkg::beat_word_t      rd_word,
  output logic                               empty,
  output logic                               almost_full
);

  import simd_upstream_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR  = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(FIFO_DEPTH);
  localparam logic [CNT_W-1:0] AFULL_CNT = CNT_W'(AFULL_LEVEL);

  beat_word_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= wr_word;
    // Read register doubles as the first pipe stage
    if (rd_en)
      rd_word <= mem[rd_ptr];
  end

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Explicit wrap, depth need not be a power of two
      if (wr_en)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign empty       = (count == '0);
  assign full        = (count == FULL_CNT);
  assign almost_full = (count >= AFULL_CNT);

  // Framer must back off on almost_full before the buffer overflows
  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst) wr_en |-> !full
  );

  // Pipe may only pull when a word is present
  a_no_underflow: assert property (
    @(posedge clk) disable iff (rst) rd_en |-> !empty
  );

endmodule

`default_nettype wire

/* upstream_msg_framer.sv */
/*
  Cuts the captured lanes into bus beats, one message per capture.
  NUM_LANES must be a multiple of the lanes per beat, with at least two beats.
  Writing stops whenever the FIFO reports almost full; no beat is dropped.
  The SIMD must hold its valids until regs_complete is seen.
*/

`timescale 1ns/1ns
`default_nettype none

module upstream_msg_framer #(
  parameter int NUM_LANES = 8
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire simd_upstream_pkg::lane_t cap_lanes [NUM_LANES],
  input  wire simd_upstream_pkg::tag_t  cap_tag,
  input  wire                           all_loaded,
  input  wire                           almost_full,
  output logic                          wr_en,
  output simd_upstream_pkg::beat_word_t wr_word,
  output logic                          regs_ready,
  output logic                          regs_complete
);

  import simd_upstream_pkg::*;

  // ----------------------------------------
  // Beat geometry
  // ----------------------------------------
  localparam int LANES_PER_BEAT = DATA_W / LANE_W;
  localparam int NUM_BEATS      = NUM_LANES / LANES_PER_BEAT;
  localparam int CNT_W          = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1;
  localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(NUM_BEATS - 1);

  framer_state_t    state;
  framer_state_t    state_nxt;
  logic [CNT_W-1:0] beat_cnt;
  logic             last_beat;
  beat_cntl_t       beat_cntl;
  beat_type_t       beat_type;
  beat_data_t       beat_data;

  assign last_beat = (beat_cnt == LAST_BEAT);

  // One beat per cycle while the FIFO has room
  // SOM goes out in the WAIT cycle itself
  assign wr_en = ((state == WAIT && all_loaded) || state == SEND) && !almost_full;

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      WAIT:
        if (wr_en)
          state_nxt = SEND;
      SEND:
        if (wr_en && last_beat)
          state_nxt = COMPLETE;
      // Hold until the SIMD lowers its valids
      COMPLETE:
        if (!all_loaded)
          state_nxt = WAIT;
      default:
        state_nxt = WAIT;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state         <= WAIT;
      beat_cnt      <= '0;
      regs_ready    <= 1'b0;
      regs_complete <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      // Counter moves only on a write, wraps after EOM
      if (wr_en)
        beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
      // Flags follow the next state so they change one cycle after the write
      regs_ready    <= (state_nxt == WAIT);
      regs_complete <= (state_nxt == COMPLETE);
    end
  end

  // ----------------------------------------
  // Beat contents
  // ----------------------------------------
  // Lower lane lands in the low half of the beat
  always_comb
  begin
    for (int i = 0; i < LANES_PER_BEAT; i++)
      beat_data[i*LANE_W +: LANE_W] = cap_lanes[int'(beat_cnt) * LANES_PER_BEAT + i];
  end

  assign beat_cntl = (beat_cnt == '0) ? CNTL_SOM :
                     last_beat        ? CNTL_EOM : CNTL_MOM;
  assign beat_type = (beat_cnt == '0) ? TYPE_DATA : TYPE_NA;

  // Tag rides on every beat as out-of-band data
  assign wr_word = {beat_cntl, beat_type, beat_data, cap_tag};

  // Guards against a corrupted state register
  a_state_legal: assert property (
    @(posedge clk) disable iff (rst)
    state inside {WAIT, SEND, COMPLETE}
  );

endmodule

`default_nettype wire

/* upstream_out_pipe.sv */
/*
  Two-stage drain from the FIFO onto the upstream bus.
  Stage one is the FIFO read register, stage two drives the bus.
  A beat moves when out_valid and out_ready are both high; outputs hold otherwise.
*/

`timescale 1ns/1ns
`default_nettype none

module upstream_out_pipe (
  input  wire                                clk,
  input  wire                                rst,
  input  wire simd_upstream_pkg::beat_word_t rd_word,
  input  wire                                empty,
  input  wire                                out_ready,
  output logic                               rd_en,
  output logic                               out_valid,
  output simd_upstream_pkg::beat_cntl_t      out_cntl,
  output simd_upstream_pkg::beat_type_t      out_type,
  output simd_upstream_pkg::beat_data_t      out_data,
  output simd_upstream_pkg::tag_t            out_oob
);

  import simd_upstream_pkg::*;

  logic       rd_valid;
  logic       rd_adv;
  logic       out_fire;
  beat_word_t out_word;

  // Bus accepts the current beat
  assign out_fire = out_valid && out_ready;
  // Read stage moves on when the bus stage is free or emptying
  assign rd_adv   = rd_valid && (!out_valid || out_fire);
  // Keep the pipe charged from the FIFO
  assign rd_en    = !empty && (!rd_valid || rd_adv);

  // ----------------------------------------
  // Stage valids
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_valid  <= 1'b0;
      out_valid <= 1'b0;
    end
    else
    begin
      if (rd_en)
        rd_valid <= 1'b1;
      else if (rd_adv)
        rd_valid <= 1'b0;

      if (rd_adv)
        out_valid <= 1'b1;
      else if (out_fire)
        out_valid <= 1'b0;
    end
  end

  // Output payload, loaded only when stage one hands over
  always_ff @(posedge clk)
  begin
    if (rd_adv)
      out_word <= rd_word;
  end

  assign {out_cntl, out_type, out_data, out_oob} = out_word;

  // A stalled beat must not change under the bus
  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_word)
  );

endmodule

`default_nettype wire
